// ==== include/tinyrv_consts.svh ====
// ------------------------------------------------------------
// TinyRV core constants
// Word width, register file size and sequence number width
// ------------------------------------------------------------
`ifndef TINYRV_CONSTS_SVH
`define TINYRV_CONSTS_SVH

// Data word width
`define RV_XLEN 32

// Architectural registers, x0 hardwired to zero
`define RV_NUM_REGS 32

// Register address width, log2 of RV_NUM_REGS
`define RV_REG_BITS 5

// Sequence number carried with every instruction
`define RV_SEQ_BITS 8

`endif

// ==== hdl/tinyrv_pkg.sv ====
// ------------------------------------------------------------
// TinyRV core types
// Micro-op encoding and the stage-to-stage message structs
// ------------------------------------------------------------
`include "tinyrv_consts.svh"

package tinyrv_pkg;

  // ----------------------------------------------------------
  // Micro-ops
  // ----------------------------------------------------------

  // ADDI decodes onto UOP_ADD with op2 taken from the immediate
  typedef enum logic [2:0] {
    UOP_ADD,
    UOP_SUB,
    UOP_AND,
    UOP_OR,
    UOP_XOR,
    UOP_SLT,
    UOP_MUL,
    UOP_ILLEGAL
  } rv_uop;

  // ----------------------------------------------------------
  // Decode to execute
  // ----------------------------------------------------------

  typedef struct packed {
    logic [`RV_SEQ_BITS-1:0] seq_num;
    rv_uop                   uop;
    logic [`RV_XLEN-1:0]     op1;
    // Register or immediate, already selected
    logic [`RV_XLEN-1:0]     op2;
    logic [`RV_REG_BITS-1:0] waddr;
    logic                    wen;
  } issue_msg;

  // ----------------------------------------------------------
  // Execute to result
  // ----------------------------------------------------------

  typedef struct packed {
    logic [`RV_SEQ_BITS-1:0] seq_num;
    logic [`RV_REG_BITS-1:0] waddr;
    logic [`RV_XLEN-1:0]     wdata;
    logic                    wen;
    // Set for any encoding outside the subset
    logic                    illegal;
  } result_msg;

endpackage

// ==== hdl/stage_intf.sv ====
// ------------------------------------------------------------
// Stage interfaces
// Generic valid/ready message bus and the writeback port
// ------------------------------------------------------------
`timescale 1ns/100ps
`include "tinyrv_consts.svh"

// Transfer on a rising edge with val and rdy both high
// msg held stable from val high until the transfer
interface stage_intf #(
  parameter type t_msg = logic
) ();

  logic val;
  logic rdy;
  t_msg msg;

  modport src (
    output val,
    output msg,
    input  rdy
  );

  modport dst (
    input  val,
    input  msg,
    output rdy
  );

endinterface

// Writeback notification, always accepted
// One val pulse writes the register and clears its pending bit
interface wb_intf ();

  logic                    val;
  logic [`RV_REG_BITS-1:0] waddr;
  logic [`RV_XLEN-1:0]     wdata;
  logic [`RV_SEQ_BITS-1:0] seq_num;

  modport src (
    output val,
    output waddr,
    output wdata,
    output seq_num
  );

  modport sink (
    input val,
    input waddr,
    input wdata,
    input seq_num
  );

endinterface

// ==== hdl/decode_issue.sv ====
// ------------------------------------------------------------
// Decode and issue stage
// Holds one instruction, decodes it, reads the register file
// and issues once no pending write blocks it
// ------------------------------------------------------------
`timescale 1ns/100ps
`include "tinyrv_consts.svh"

module decode_issue (
  input  logic        clk,
  input  logic        rst,
  input  logic        inst_val,
  output logic        inst_rdy,
  input  logic [31:0] inst,
  input  logic [`RV_SEQ_BITS-1:0] seq_num,
  stage_intf.src      issue,
  wb_intf.sink        wb
);

  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // ----------------------------------------------------------
  // Input register
  // ----------------------------------------------------------

  logic                    in_val;
  logic [31:0]             in_inst;
  logic [`RV_SEQ_BITS-1:0] in_seq;
  logic                    inst_fire;
  logic                    issue_fire;

  assign inst_fire  = inst_val & inst_rdy;
  assign issue_fire = issue.val & issue.rdy;
  // Free slot, or the held instruction leaves this cycle
  assign inst_rdy   = ~in_val | issue_fire;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_val <= 1'b0;
    end else if (inst_fire) begin
      in_val <= 1'b1;
    end else if (issue_fire) begin
      in_val <= 1'b0;
    end
  end

  // Held instruction word and its sequence number
  always_ff @(posedge clk) begin
    if (inst_fire) begin
      in_inst <= inst;
      in_seq  <= seq_num;
    end
  end

  // ----------------------------------------------------------
  // Decoder
  // ----------------------------------------------------------

  logic [6:0]              opcode;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [`RV_REG_BITS-1:0] rs1;
  logic [`RV_REG_BITS-1:0] rs2;
  logic [`RV_REG_BITS-1:0] rd;
  tinyrv_pkg::rv_uop       uop;
  logic                    use_rs2;
  logic                    legal;
  logic                    wen;
  logic [`RV_XLEN-1:0]     imm;

  assign opcode = in_inst[6:0];
  assign rd     = in_inst[11:7];
  assign funct3 = in_inst[14:12];
  assign rs1    = in_inst[19:15];
  assign rs2    = in_inst[24:20];
  assign funct7 = in_inst[31:25];

  always_comb begin
    uop     = tinyrv_pkg::UOP_ILLEGAL;
    use_rs2 = 1'b0;
    case (opcode)
      OPC_OP: begin
        use_rs2 = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: uop = tinyrv_pkg::UOP_ADD;
          10'b0100000_000: uop = tinyrv_pkg::UOP_SUB;
          10'b0000000_111: uop = tinyrv_pkg::UOP_AND;
          10'b0000000_110: uop = tinyrv_pkg::UOP_OR;
          10'b0000000_100: uop = tinyrv_pkg::UOP_XOR;
          10'b0000000_010: uop = tinyrv_pkg::UOP_SLT;
          10'b0000001_000: uop = tinyrv_pkg::UOP_MUL;
          default:         uop = tinyrv_pkg::UOP_ILLEGAL;
        endcase
      end
      // Only ADDI in the immediate group
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin
          uop = tinyrv_pkg::UOP_ADD;
        end
      end
      default: uop = tinyrv_pkg::UOP_ILLEGAL;
    endcase
  end

  assign legal = (uop != tinyrv_pkg::UOP_ILLEGAL);
  // x0 as destination never writes
  assign wen   = legal & (rd != '0);
  // I-type immediate, sign-extended
  assign imm   = {{(`RV_XLEN-12){in_inst[31]}}, in_inst[31:20]};

  // ----------------------------------------------------------
  // Register file and scoreboard
  // ----------------------------------------------------------

  logic [`RV_XLEN-1:0]     regs     [`RV_NUM_REGS];
  logic [`RV_NUM_REGS-1:0] pending;
  logic [`RV_SEQ_BITS-1:0] pend_seq [`RV_NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.val && (wb.waddr != '0)) begin
      regs[wb.waddr] <= wb.wdata;
    end
  end

  // Set on issue wins over clear, though WAW stall keeps them apart
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      if (wb.val) begin
        pending[wb.waddr] <= 1'b0;
      end
      if (issue_fire && wen) begin
        pending[rd] <= 1'b1;
      end
    end
  end

  // Sequence number of the in-flight writer per register
  always_ff @(posedge clk) begin
    if (issue_fire && wen) begin
      pend_seq[rd] <= in_seq;
    end
  end

  // ----------------------------------------------------------
  // Hazards and issue
  // ----------------------------------------------------------

  logic stall;

  // RAW on used sources, WAW on rd
  assign stall = legal & (pending[rs1] | (use_rs2 & pending[rs2]) | (wen & pending[rd]));

  assign issue.val = in_val & ~stall;

  always_comb begin
    issue.msg.seq_num = in_seq;
    issue.msg.uop     = uop;
    issue.msg.op1     = regs[rs1];
    issue.msg.op2     = use_rs2 ? regs[rs2] : imm;
    issue.msg.waddr   = rd;
    issue.msg.wen     = wen;
  end

  // ----------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------

  // x0 never tracked as an outstanding write
  x0_never_pending: assert property (@(posedge clk) disable iff (rst)
    !pending[0]);

  // Writeback only for a pending register, from its latest writer
  wb_matches_pending: assert property (@(posedge clk) disable iff (rst)
    wb.val |-> (pending[wb.waddr] && (pend_seq[wb.waddr] == wb.seq_num)));

endmodule

// ==== hdl/execute_alu.sv ====
// ------------------------------------------------------------
// Execute stage
// Single-cycle ALU feeding a result register with back-pressure
// ------------------------------------------------------------
`timescale 1ns/100ps

module execute_alu (
  input  logic   clk,
  input  logic   rst,
  stage_intf.dst in_bus,
  stage_intf.src out_bus
);

  tinyrv_pkg::issue_msg  in_msg;
  tinyrv_pkg::result_msg alu_res;
  tinyrv_pkg::result_msg out_q;
  logic                  out_val;
  logic                  in_fire;
  logic                  out_fire;

  assign in_msg = in_bus.msg;

  // ----------------------------------------------------------
  // ALU
  // ----------------------------------------------------------

  always_comb begin
    alu_res.seq_num = in_msg.seq_num;
    alu_res.waddr   = in_msg.waddr;
    alu_res.wen     = in_msg.wen;
    alu_res.illegal = 1'b0;
    case (in_msg.uop)
      tinyrv_pkg::UOP_ADD: alu_res.wdata = in_msg.op1 + in_msg.op2;
      tinyrv_pkg::UOP_SUB: alu_res.wdata = in_msg.op1 - in_msg.op2;
      tinyrv_pkg::UOP_AND: alu_res.wdata = in_msg.op1 & in_msg.op2;
      tinyrv_pkg::UOP_OR:  alu_res.wdata = in_msg.op1 | in_msg.op2;
      tinyrv_pkg::UOP_XOR: alu_res.wdata = in_msg.op1 ^ in_msg.op2;
      // Signed compare, zero-extended flag
      tinyrv_pkg::UOP_SLT:
        alu_res.wdata = {{($bits(alu_res.wdata)-1){1'b0}},
                         ($signed(in_msg.op1) < $signed(in_msg.op2))};
      // Low word of the product
      tinyrv_pkg::UOP_MUL: alu_res.wdata = in_msg.op1 * in_msg.op2;
      default: begin
        alu_res.wdata   = '0;
        alu_res.illegal = 1'b1;
      end
    endcase
  end

  // ----------------------------------------------------------
  // Output register
  // ----------------------------------------------------------

  assign out_fire   = out_val & out_bus.rdy;
  // Empty, or draining this cycle
  assign in_bus.rdy = ~out_val | out_fire;
  assign in_fire    = in_bus.val & in_bus.rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_val <= 1'b0;
    end else if (in_fire) begin
      out_val <= 1'b1;
    end else if (out_fire) begin
      out_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      out_q <= alu_res;
    end
  end

  assign out_bus.val = out_val;
  assign out_bus.msg = out_q;

  // Stalled result holds until the result stage takes it
  out_stable: assert property (@(posedge clk) disable iff (rst)
    (out_bus.val && !out_bus.rdy) |=> (out_bus.val && $stable(out_bus.msg)));

endmodule

// ==== hdl/result_writeback.sv ====
// ------------------------------------------------------------
// Result stage
// Completion register toward the core outputs, and writeback
// ------------------------------------------------------------
`timescale 1ns/100ps
`include "tinyrv_consts.svh"

module result_writeback (
  input  logic                    clk,
  input  logic                    rst,
  stage_intf.dst                  in_bus,
  output logic                    cmpl_val,
  input  logic                    cmpl_rdy,
  output logic [`RV_SEQ_BITS-1:0] cmpl_seq_num,
  output logic [`RV_REG_BITS-1:0] cmpl_waddr,
  output logic [`RV_XLEN-1:0]     cmpl_wdata,
  output logic                    cmpl_wen,
  output logic                    cmpl_illegal,
  wb_intf.src                     wb
);

  tinyrv_pkg::result_msg cmpl_q;
  logic                  cmpl_fire;
  logic                  in_fire;

  assign cmpl_fire  = cmpl_val & cmpl_rdy;
  assign in_bus.rdy = ~cmpl_val | cmpl_fire;
  assign in_fire    = in_bus.val & in_bus.rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      cmpl_val <= 1'b0;
    end else if (in_fire) begin
      cmpl_val <= 1'b1;
    end else if (cmpl_fire) begin
      cmpl_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      cmpl_q <= in_bus.msg;
    end
  end

  // Completion ports straight from the register
  assign cmpl_seq_num = cmpl_q.seq_num;
  assign cmpl_waddr   = cmpl_q.waddr;
  assign cmpl_wdata   = cmpl_q.wdata;
  assign cmpl_wen     = cmpl_q.wen;
  assign cmpl_illegal = cmpl_q.illegal;

  // Write back in the same edge the completion leaves
  assign wb.val     = cmpl_fire & cmpl_q.wen;
  assign wb.waddr   = cmpl_q.waddr;
  assign wb.wdata   = cmpl_q.wdata;
  assign wb.seq_num = cmpl_q.seq_num;

  // A written-back completion has left the register one cycle later
  wb_on_cmpl: assert property (@(posedge clk) disable iff (rst)
    wb.val |=> (!cmpl_val || (cmpl_seq_num != $past(wb.seq_num))));

endmodule

// ==== hdl/tinyrv_core.sv ====
// ------------------------------------------------------------
// TinyRV core back end
// Decode-issue, execute and result stages behind plain ports
// ------------------------------------------------------------
`timescale 1ns/100ps
`include "tinyrv_consts.svh"

module tinyrv_core (
  input  logic                    clk,
  input  logic                    rst,
  // Instruction stream
  input  logic                    inst_val,
  output logic                    inst_rdy,
  input  logic [31:0]             inst,
  input  logic [`RV_SEQ_BITS-1:0] seq_num,
  // Completion stream
  output logic                    cmpl_val,
  input  logic                    cmpl_rdy,
  output logic [`RV_SEQ_BITS-1:0] cmpl_seq_num,
  output logic [`RV_REG_BITS-1:0] cmpl_waddr,
  output logic [`RV_XLEN-1:0]     cmpl_wdata,
  output logic                    cmpl_wen,
  output logic                    cmpl_illegal
);

  // ----------------------------------------------------------
  // Stage buses
  // ----------------------------------------------------------

  stage_intf #(.t_msg(tinyrv_pkg::issue_msg))  issue_bus ();
  stage_intf #(.t_msg(tinyrv_pkg::result_msg)) result_bus ();
  wb_intf                                      wb_bus ();

  // ----------------------------------------------------------
  // Stages
  // ----------------------------------------------------------

  decode_issue decode_issue_inst (
    .clk      (clk),
    .rst      (rst),
    .inst_val (inst_val),
    .inst_rdy (inst_rdy),
    .inst     (inst),
    .seq_num  (seq_num),
    .issue    (issue_bus.src),
    .wb       (wb_bus.sink)
  );

  execute_alu execute_alu_inst (
    .clk     (clk),
    .rst     (rst),
    .in_bus  (issue_bus.dst),
    .out_bus (result_bus.src)
  );

  result_writeback result_writeback_inst (
    .clk          (clk),
    .rst          (rst),
    .in_bus       (result_bus.dst),
    .cmpl_val     (cmpl_val),
    .cmpl_rdy     (cmpl_rdy),
    .cmpl_seq_num (cmpl_seq_num),
    .cmpl_waddr   (cmpl_waddr),
    .cmpl_wdata   (cmpl_wdata),
    .cmpl_wen     (cmpl_wen),
    .cmpl_illegal (cmpl_illegal),
    .wb           (wb_bus.src)
  );

endmodule

// ==== tb/tinyrv_core_tb.sv ====
// ------------------------------------------------------------
// TinyRV core testbench
// Random instruction stream checked against a shadow register
// model by concurrent assertions on every completion
// ------------------------------------------------------------
`timescale 1ns/100ps
`include "tinyrv_consts.svh"

module tinyrv_core_tb;

  localparam int         NUM_INST       = 300;
  localparam int         TIMEOUT_CYCLES = 200;
  localparam logic [6:0] OPC_OP         = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM     = 7'b0010011;

  logic                    clk;
  logic                    rst;
  logic                    inst_val;
  logic                    inst_rdy;
  logic [31:0]             inst;
  logic [`RV_SEQ_BITS-1:0] seq_num;
  logic                    cmpl_val;
  logic                    cmpl_rdy;
  logic [`RV_SEQ_BITS-1:0] cmpl_seq_num;
  logic [`RV_REG_BITS-1:0] cmpl_waddr;
  logic [`RV_XLEN-1:0]     cmpl_wdata;
  logic                    cmpl_wen;
  logic                    cmpl_illegal;

  // Reference model state
  logic [31:0]             sent_q [$];
  logic [`RV_XLEN-1:0]     shadow [`RV_NUM_REGS];
  logic [`RV_SEQ_BITS-1:0] exp_seq;
  logic [`RV_REG_BITS-1:0] exp_waddr;
  logic [`RV_XLEN-1:0]     exp_wdata;
  logic                    exp_wen;
  logic                    exp_illegal;
  int                      sent_cnt  = 0;
  int                      done_cnt  = 0;
  int                      val_errs  = 0;
  int                      hang_errs = 0;
  logic [31:0]             inst_rng;
  logic [31:0]             rdy_rng;

  tinyrv_core tinyrv_core_inst (
    .clk          (clk),
    .rst          (rst),
    .inst_val     (inst_val),
    .inst_rdy     (inst_rdy),
    .inst         (inst),
    .seq_num      (seq_num),
    .cmpl_val     (cmpl_val),
    .cmpl_rdy     (cmpl_rdy),
    .cmpl_seq_num (cmpl_seq_num),
    .cmpl_waddr   (cmpl_waddr),
    .cmpl_wdata   (cmpl_wdata),
    .cmpl_wen     (cmpl_wen),
    .cmpl_illegal (cmpl_illegal)
  );

  // 4 ns clock
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Stimulus and reference helpers
  // ----------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Registers x0..x7 only, so hazards come often
  function automatic logic [31:0] make_inst(input logic [31:0] r);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm;
    rd  = {2'b00, r[2:0]};
    rs1 = {2'b00, r[5:3]};
    rs2 = {2'b00, r[8:6]};
    imm = r[23:12];
    // About 5 percent illegal, as a bad funct7 or a branch opcode
    if (r[31:26] < 6'd3) begin
      if (r[24]) return {7'b0000010, rs2, rs1, 3'b000, rd, OPC_OP};
      return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b1100011};
    end
    case (r[11:9])
      3'd0:    return {7'b0000000, rs2, rs1, 3'b000, rd, OPC_OP};
      3'd1:    return {7'b0100000, rs2, rs1, 3'b000, rd, OPC_OP};
      3'd2:    return {7'b0000000, rs2, rs1, 3'b111, rd, OPC_OP};
      3'd3:    return {7'b0000000, rs2, rs1, 3'b110, rd, OPC_OP};
      3'd4:    return {7'b0000000, rs2, rs1, 3'b100, rd, OPC_OP};
      3'd5:    return {7'b0000000, rs2, rs1, 3'b010, rd, OPC_OP};
      3'd6:    return {7'b0000001, rs2, rs1, 3'b000, rd, OPC_OP};
      default: return {imm, rs1, 3'b000, rd, OPC_OP_IMM};
    endcase
  endfunction

  // Arithmetic subset of RV32IM plus addi
  function automatic logic inst_legal(input logic [31:0] ins);
    logic [9:0] f;
    f = {ins[31:25], ins[14:12]};
    if (ins[6:0] == OPC_OP_IMM) return ins[14:12] == 3'b000;
    if (ins[6:0] != OPC_OP) return 1'b0;
    return f inside {10'b0000000_000, 10'b0100000_000, 10'b0000000_111,
                     10'b0000000_110, 10'b0000000_100, 10'b0000000_010,
                     10'b0000001_000};
  endfunction

  // Expected result from the shadow registers
  function automatic logic [`RV_XLEN-1:0] ref_wdata(input logic [31:0] ins);
    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;
    logic [9:0]          f;
    a = shadow[ins[19:15]];
    b = shadow[ins[24:20]];
    f = {ins[31:25], ins[14:12]};
    if (!inst_legal(ins)) return '0;
    if (ins[6:0] == OPC_OP_IMM) return a + {{(`RV_XLEN-12){ins[31]}}, ins[31:20]};
    case (f)
      10'b0100000_000: return a - b;
      10'b0000000_111: return a & b;
      10'b0000000_110: return a | b;
      10'b0000000_100: return a ^ b;
      10'b0000000_010: return ($signed(a) < $signed(b)) ? `RV_XLEN'(1) : '0;
      10'b0000001_000: return a * b;
      default:         return a + b;
    endcase
  endfunction

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------

  // Retire the head on a handshake, then set up the next expectation
  always @(posedge clk) begin
    logic [31:0] head;
    if (!rst) begin
      if (cmpl_val && cmpl_rdy && sent_q.size() > 0) begin
        if (exp_wen) shadow[exp_waddr] = exp_wdata;
        void'(sent_q.pop_front());
        done_cnt++;
      end
      if (sent_q.size() > 0) begin
        head        = sent_q[0];
        exp_seq     = done_cnt[`RV_SEQ_BITS-1:0];
        exp_waddr   = head[11:7];
        exp_illegal = !inst_legal(head);
        exp_wen     = !exp_illegal && (head[11:7] != '0);
        exp_wdata   = ref_wdata(head);
      end
    end
  end

  // ----------------------------------------------------------
  // Checks
  // ----------------------------------------------------------

  wdata_check: assert property (@(posedge clk) disable iff (rst)
    (cmpl_val && cmpl_rdy) |-> (cmpl_wdata == exp_wdata))
    else begin
      val_errs++;
      $display("FAIL %0t: seq %0d wdata %h, expected %h", $time,
               $sampled(cmpl_seq_num), $sampled(cmpl_wdata), $sampled(exp_wdata));
    end

  // Destination, write enable and illegal flag together
  fields_check: assert property (@(posedge clk) disable iff (rst)
    (cmpl_val && cmpl_rdy) |->
      ({cmpl_waddr, cmpl_wen, cmpl_illegal} == {exp_waddr, exp_wen, exp_illegal}))
    else begin
      val_errs++;
      $display("FAIL %0t: seq %0d waddr/wen/illegal %0d/%b/%b, expected %0d/%b/%b",
               $time, $sampled(cmpl_seq_num), $sampled(cmpl_waddr), $sampled(cmpl_wen),
               $sampled(cmpl_illegal), $sampled(exp_waddr), $sampled(exp_wen),
               $sampled(exp_illegal));
    end

  // In order, one step per completion
  seq_check: assert property (@(posedge clk) disable iff (rst)
    (cmpl_val && cmpl_rdy) |-> (cmpl_seq_num == exp_seq))
    else begin
      val_errs++;
      $display("FAIL %0t: seq %0d, expected %0d", $time,
               $sampled(cmpl_seq_num), $sampled(exp_seq));
    end

  extra_check: assert property (@(posedge clk) disable iff (rst)
    cmpl_val |-> (done_cnt < sent_cnt))
    else begin
      val_errs++;
      $display("FAIL %0t: completion with nothing outstanding", $time);
    end

  // x0 and illegal encodings never write
  no_write_check: assert property (@(posedge clk) disable iff (rst)
    (cmpl_val && (cmpl_waddr == '0 || cmpl_illegal)) |-> !cmpl_wen)
    else begin
      val_errs++;
      $display("FAIL %0t: write enable set for x0 or illegal", $time);
    end

  idle_check: assert property (@(posedge clk) disable iff (rst)
    (sent_cnt == 0) |-> (!cmpl_val && inst_rdy))
    else begin
      val_errs++;
      $display("FAIL %0t: core not idle before the first instruction", $time);
    end

  // ----------------------------------------------------------
  // Drivers
  // ----------------------------------------------------------

  // Completion back-pressure, low about 30 percent of cycles
  initial begin
    cmpl_rdy = 1'b0;
    rdy_rng  = 32'd76 ^ 32'h9e37_79b9;
    forever begin
      @(posedge clk);
      #1;
      rdy_rng  = xorshift32(rdy_rng);
      cmpl_rdy = (rdy_rng % 100) >= 30;
    end
  end

  initial begin
    logic [31:0] next_inst;
    logic        accepted;
    int          waited;
    rst         = 1'b1;
    inst_val    = 1'b0;
    inst        = '0;
    seq_num     = '0;
    inst_rng    = 32'd76;
    exp_seq     = '0;
    exp_waddr   = '0;
    exp_wdata   = '0;
    exp_wen     = 1'b0;
    exp_illegal = 1'b0;
    for (int r = 0; r < `RV_NUM_REGS; r++) begin
      shadow[r] = '0;
    end
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;

    for (int i = 0; i < NUM_INST && hang_errs == 0; i++) begin
      inst_rng  = xorshift32(inst_rng);
      next_inst = make_inst(inst_rng);
      inst_val  = 1'b1;
      inst      = next_inst;
      seq_num   = i[`RV_SEQ_BITS-1:0];
      waited    = 0;
      accepted  = 1'b0;
      // Handshake when ready is seen high in the middle of the cycle
      do begin
        @(negedge clk);
        accepted = inst_rdy;
        @(posedge clk);
        waited++;
      end while (!accepted && waited < TIMEOUT_CYCLES);
      if (accepted) begin
        sent_q.push_back(next_inst);
        sent_cnt++;
      end else begin
        hang_errs++;
        $display("Timeout: instruction %0d not accepted within %0d cycles", i,
                 TIMEOUT_CYCLES);
      end
      #1;
    end
    inst_val = 1'b0;

    // Drain the pipeline
    waited = 0;
    while (hang_errs == 0 && done_cnt < sent_cnt && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (hang_errs == 0 && done_cnt != NUM_INST) begin
      hang_errs++;
      $display("Timeout: only %0d of %0d instructions completed", done_cnt, NUM_INST);
    end

    $display("Completions %0d of %0d, value errors %0d, timeouts %0d", done_cnt,
             NUM_INST, val_errs, hang_errs);
    if (val_errs == 0 && hang_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== tinyrv_core.f ====
+incdir+include
hdl/tinyrv_pkg.sv
hdl/stage_intf.sv
hdl/decode_issue.sv
hdl/execute_alu.sv
hdl/result_writeback.sv
hdl/tinyrv_core.sv
tb/tinyrv_core_tb.sv

// ==== Makefile ====
# Verilator build and run of the TinyRV core testbench

SIM  := obj_dir/Vtinyrv_core_tb
SRCS := $(filter-out +incdir+%,$(shell cat tinyrv_core.f))
HDRS := $(wildcard include/*.svh)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source, a header or the file list changes
$(SIM): tinyrv_core.f $(SRCS) $(HDRS)
	verilator --binary --assert -j 0 -f tinyrv_core.f --top-module tinyrv_core_tb \
	  -Mdir obj_dir -o Vtinyrv_core_tb

# Status comes from the search for the pass line
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
